/* list.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/controlPkg.sv
hdl/subDecodeIf.sv
hdl/specialDecoder.sv
hdl/regimmDecoder.sv
hdl/primaryDecoder.sv
hdl/decodeUnit.sv
bench/decodeUnitTb.sv

/* Bender.yml */
package:
  name: decode_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/controlPkg.sv
      - hdl/subDecodeIf.sv
      - hdl/specialDecoder.sv
      - hdl/regimmDecoder.sv
      - hdl/primaryDecoder.sv
      - hdl/decodeUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/decodeUnitTb.sv

/* bench/decodeUnitTb.sv */
`include "mips_params.svh"

`default_nettype none

module decodeUnitTb;
    timeunit 1ns;
    timeprecision 100ps;
    import controlPkg::*;

    localparam bit implementLikely = `IMPLEMENT_LIKELY_DEFAULT;
    localparam int bubbleCount = 12;
    localparam int specialCount = 40;
    localparam int itypeCount = 40;
    localparam int branchCount = 40;
    localparam int unknownCount = 30;
    localparam int streamCount = 200;
    // reset plus each batch and its two closing cycles
    localparam int testCycles = 8 + bubbleCount + specialCount + itypeCount + branchCount
                                + unknownCount + streamCount + 2 * 6;

    localparam logic [5:0] specialFuncts [20] = '{
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0C, 6'h0D,
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B};
    localparam logic [5:0] itypeOps [16] = '{
        6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F,
        6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2B};
    localparam logic [31:0] branchBases [18] = '{
        32'h1000_0000, 32'h1400_0000, 32'h1800_0000, 32'h1C00_0000,
        32'h5000_0000, 32'h5400_0000, 32'h5800_0000, 32'h5C00_0000,
        32'h0800_0000, 32'h0C00_0000, 32'h0400_0000, 32'h0401_0000,
        32'h0402_0000, 32'h0403_0000, 32'h0410_0000, 32'h0411_0000,
        32'h0412_0000, 32'h0413_0000};
    // cop0, SPECIAL2, mult/div, traps, unused codes, ll/sc, unaligned
    localparam logic [31:0] unknownWords [26] = '{
        32'h4000_0000, 32'h7000_0000, 32'h0000_0018, 32'h0000_0019,
        32'h0000_001A, 32'h0000_001B, 32'h0000_0010, 32'h0000_0011,
        32'h0000_0012, 32'h0000_0013, 32'h0000_0030, 32'h0000_0032,
        32'h0000_0034, 32'h0000_0036, 32'h0000_0001, 32'h0000_003F,
        32'h0408_0000, 32'h040C_0000, 32'h0404_0000, 32'h041F_0000,
        32'hC000_0000, 32'hE000_0000, 32'h8800_0000, 32'h9800_0000,
        32'hA800_0000, 32'hB800_0000};

    logic clk;
    logic rstN;
    logic [`WORD_WIDTH-1:0] instruction;
    logic bubble;
    controlSignals_t controls;

    logic [31:0] lfsrState;
    int checkCount = 0;
    int errorCount = 0;

    decodeUnit dut (
        .clk(clk),
        .rstN(rstN),
        .instruction(instruction),
        .bubble(bubble),
        .controls(controls)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // register fields that may vary without changing the decode
    function automatic logic [31:0] fieldMask(input logic [5:0] op);
        if (op == 6'h00)
            return 32'h03FF_FFC0;
        else if (op == 6'h01)
            return 32'h03E0_FFFF;
        else
            return 32'h03FF_FFFF;
    endfunction

    function automatic controlSignals_t expectedControls(input logic [31:0] instr,
                                                         input logic squash);
        controlSignals_t c;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [31:0] sImm;
        c = controlNop;
        op = instr[31:26];
        fn = instr[5:0];
        rs = instr[25:21];
        rt = instr[20:16];
        rd = instr[15:11];
        sImm = {{16{instr[15]}}, instr[15:0]};
        if (squash)
            return controlNop;
        case (op)
            6'h00:
            case (fn)
                6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B:
                begin
                    c.regRead1 = rs;
                    c.regRead2 = rt;
                    c.destinationRegister = rd;
                    c.grfWriteSource = grfAlu;
                    c.checkOverflow = (fn == 6'h20) || (fn == 6'h22);
                    case (fn)
                        6'h20, 6'h21: c.aluCtrl = aluAdd;
                        6'h22, 6'h23: c.aluCtrl = aluSub;
                        6'h24: c.aluCtrl = aluAnd;
                        6'h25: c.aluCtrl = aluOr;
                        6'h26: c.aluCtrl = aluXor;
                        6'h27: c.aluCtrl = aluNor;
                        6'h2A: c.aluCtrl = aluSlt;
                        default: c.aluCtrl = aluSltu;
                    endcase
                end
                6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07:
                begin
                    c.regRead1 = rt;
                    c.destinationRegister = rd;
                    c.grfWriteSource = grfAlu;
                    c.aluCtrl = (fn[1:0] == 2'b00) ? aluShiftLeft :
                                (fn[0] ? aluArithmeticShiftRight : aluShiftRight);
                    if (fn[2])
                        c.regRead2 = rs; // variable amount
                    else
                    begin
                        c.aluSrc = 1'b1;
                        c.immediate = {27'b0, instr[10:6]};
                    end
                end
                6'h08, 6'h09:
                begin
                    c.regRead1 = rs;
                    c.absJump = 1'b1;
                    c.absJumpLoc = jumpRegister;
                    if (fn[0])
                    begin
                        c.grfWriteSource = grfPc;
                        c.destinationRegister = rd;
                    end
                end
                6'h0C: c.exception = excSyscall;
                6'h0D: c.exception = excBreak;
                default: c.exception = excUnknownInstruction;
            endcase
            6'h01:
            case (rt)
                5'h00, 5'h01, 5'h02, 5'h03, 5'h10, 5'h11, 5'h12, 5'h13:
                begin
                    c.regRead1 = rs;
                    c.branch = 1'b1;
                    c.immediate = sImm;
                    c.cmpCtrl = rt[0] ? cmpGreaterEqualZero : cmpLessThanZero;
                    c.branchLikely = rt[1];
                    if (rt[4])
                    begin
                        c.grfWriteSource = grfPc;
                        c.destinationRegister = `REG_INDEX_WIDTH'(`LINK_REGISTER);
                    end
                end
                default: c.exception = excUnknownInstruction;
            endcase
            6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F:
            begin
                c.regRead1 = rs;
                c.destinationRegister = rt;
                c.grfWriteSource = grfAlu;
                c.aluSrc = 1'b1;
                c.checkOverflow = (op == 6'h08);
                c.immediate = sImm;
                case (op)
                    6'h0A: c.aluCtrl = aluSlt;
                    6'h0B: c.aluCtrl = aluSltu;
                    6'h0C: c.aluCtrl = aluAnd;
                    6'h0D: c.aluCtrl = aluOr;
                    6'h0E: c.aluCtrl = aluXor;
                    default: c.aluCtrl = aluAdd;
                endcase
                if (op == 6'h0C || op == 6'h0D || op == 6'h0E)
                    c.immediate = {16'h0, instr[15:0]};
                else if (op == 6'h0F)
                    c.immediate = {instr[15:0], 16'h0}; // lui
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2B:
            begin
                c.regRead1 = rs;
                c.immediate = sImm;
                c.calculateAddress = 1'b1;
                c.memWidthCtrl = (op[1:0] == 2'b11) ? memWidth4 :
                                 (op[0] ? memWidth2 : memWidth1);
                if (op[3])
                begin
                    c.regRead2 = rt;
                    c.memStore = 1'b1;
                end
                else
                begin
                    c.memLoad = 1'b1;
                    c.grfWriteSource = grfMem;
                    c.destinationRegister = rt;
                    c.memReadSignExtend = (op == 6'h20) || (op == 6'h21);
                end
            end
            6'h04, 6'h05, 6'h06, 6'h07, 6'h14, 6'h15, 6'h16, 6'h17:
            begin
                c.regRead1 = rs;
                c.branch = 1'b1;
                c.immediate = sImm;
                c.branchLikely = op[4];
                if (!op[1])
                    c.regRead2 = rt; // beq and bne compare two registers
                case (op[1:0])
                    2'b00: c.cmpCtrl = cmpEqual;
                    2'b01: c.cmpCtrl = cmpNotEqual;
                    2'b10: c.cmpCtrl = cmpLessEqualZero;
                    default: c.cmpCtrl = cmpGreaterThanZero;
                endcase
            end
            6'h02, 6'h03:
            begin
                c.absJump = 1'b1;
                c.immediate = {6'h0, instr[25:0]};
                if (op[0])
                begin
                    c.grfWriteSource = grfPc;
                    c.destinationRegister = `REG_INDEX_WIDTH'(`LINK_REGISTER);
                end
            end
            default: c.exception = excUnknownInstruction;
        endcase
        if (!implementLikely && c.branchLikely)
            c.exception = excUnknownInstruction;
        return c;
    endfunction

    task automatic checkControls(input controlSignals_t expected, input controlSignals_t actual,
                                 input logic [31:0] word);
        controlSignals_t e;
        controlSignals_t a;
        e = expected;
        a = actual;
        e.exception = excNone; // compared on its own
        a.exception = excNone;
        checkCount++;
        if (a !== e)
        begin
            errorCount++;
            $display("Fail controls for instruction %h: expected %h, got %h", word, e, a);
        end
    endtask

    task automatic checkException(input exception_t expected, input exception_t actual,
                                  input logic [31:0] word);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail controls.exception for instruction %h: expected %h, got %h",
                     word, expected, actual);
        end
    endtask

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < count; b++)
        begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic drawWord(input int category, output logic [31:0] word);
        logic [31:0] pick;
        logic [31:0] fields;
        logic [31:0] base;
        drawBits(8, pick);
        drawBits(32, fields);
        case (category)
            0: base = {26'h0, specialFuncts[pick % 20]};
            1: base = {itypeOps[pick % 16], 26'h0};
            2: base = branchBases[pick % 18];
            default: base = unknownWords[pick % 26];
        endcase
        word = base | (fields & fieldMask(base[31:26]));
    endtask

    task automatic applyWord(input logic [31:0] word, input logic squash);
        @(negedge clk);
        instruction = word;
        bubble = squash;
    endtask

    // category -1 mixes all tables; bubbleMode 0 never, 1 always, 2 now and then
    task automatic runBatch(input string name, input int count, input int category,
                            input int bubbleMode);
        int errorsBefore;
        int kind;
        logic squash;
        logic [31:0] draw;
        logic [31:0] word;
        errorsBefore = errorCount;
        for (int n = 0; n < count; n++)
        begin
            kind = category;
            squash = (bubbleMode == 1);
            if (category < 0)
            begin
                drawBits(2, draw);
                kind = draw;
            end
            if (bubbleMode == 2)
            begin
                drawBits(3, draw);
                squash = (draw == 0);
            end
            drawWord(kind, word);
            applyWord(word, squash);
        end
        applyWord(32'h0, 1'b1); // idle cycle flushes the last result
        @(posedge clk);
        $display("test %s: %0d instructions, %0d errors", name, count,
                 errorCount - errorsBefore);
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // expectation taken at the sampling edge, compared once the register settles
    initial
    begin
        controlSignals_t expected;
        logic [31:0] sampledWord;
        forever
        begin
            @(posedge clk);
            sampledWord = instruction;
            expected = expectedControls(instruction, bubble || !rstN);
            @(negedge clk);
            checkControls(expected, controls, sampledWord);
            checkException(expected.exception, controls.exception, sampledWord);
        end
    end

    initial
    begin
        #(2 * testCycles * 20);
        $display("timeout: decode run did not finish within %0d ns", 2 * testCycles * 20);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        lfsrState = 32'd85839;
        rstN = 1'b0;
        bubble = 1'b0;
        instruction = 32'h2108_0001; // addi, decodes to a non-nop bundle
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        bubble = 1'b1;
        instruction = '0;
        @(posedge clk);
        @(negedge clk);
        @(posedge clk);
        $display("test reset: %0d errors", errorCount);

        runBatch("bubble", bubbleCount, -1, 1);
        runBatch("special", specialCount, 0, 0);
        runBatch("itype", itypeCount, 1, 0);
        runBatch("branch", branchCount, 2, 0);
        runBatch("unknown", unknownCount, 3, 0);
        runBatch("stream", streamCount, -1, 2);

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/decodeUnit.sv */
`include "mips_params.svh"

`default_nettype none

module decodeUnit #(
    parameter bit implementLikely = `IMPLEMENT_LIKELY_DEFAULT
) (
    input logic clk,
    input logic rstN,
    input logic [`WORD_WIDTH-1:0] instruction,
    input logic bubble,
    output controlPkg::controlSignals_t controls
);

    subDecodeIf specialBus ();
    subDecodeIf regimmBus ();

    primaryDecoder #(
        .implementLikely(implementLikely)
    ) primary (
        .clk(clk),
        .rstN(rstN),
        .instruction(instruction),
        .bubble(bubble),
        .specialBus(specialBus.merger),
        .regimmBus(regimmBus.merger),
        .controls(controls)
    );

    specialDecoder special (
        .bus(specialBus.decoder)
    );

    regimmDecoder regimm (
        .bus(regimmBus.decoder)
    );

endmodule

`default_nettype wire

/* hdl/primaryDecoder.sv */
`include "mips_params.svh"

`default_nettype none

module primaryDecoder #(
    parameter bit implementLikely = `IMPLEMENT_LIKELY_DEFAULT
) (
    input logic clk,
    input logic rstN,
    input logic [`WORD_WIDTH-1:0] instruction,
    input logic bubble,
    subDecodeIf.merger specialBus,
    subDecodeIf.merger regimmBus,
    output controlPkg::controlSignals_t controls
);
    import isaPkg::*;
    import controlPkg::*;

    instrWord_t word;
    logic [`WORD_WIDTH-1:0] signImm;
    logic [`WORD_WIDTH-1:0] zeroImm;
    controlSignals_t decoded;

    assign word = instruction;
    assign signImm = {{(`WORD_WIDTH-16){word.i.imm16[15]}}, word.i.imm16};
    assign zeroImm = {{(`WORD_WIDTH-16){1'b0}}, word.i.imm16};

    assign specialBus.instr = word;
    assign specialBus.signImm = signImm;
    assign specialBus.zeroImm = zeroImm;
    assign regimmBus.instr = word;
    assign regimmBus.signImm = signImm;
    assign regimmBus.zeroImm = zeroImm;

    always_comb
    begin
        decoded = controlNop;
        case (word.i.opcode)
            opSpecial:
            begin
                decoded = specialBus.ctrl;
                if (specialBus.unknown)
                    decoded.exception = excUnknownInstruction;
            end
            opRegimm:
            begin
                decoded = regimmBus.ctrl;
                if (regimmBus.unknown)
                    decoded.exception = excUnknownInstruction;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                decoded.regRead1 = word.i.rs;
                decoded.grfWriteSource = grfAlu;
                decoded.destinationRegister = word.i.rt;
                decoded.aluSrc = 1'b1;
                decoded.immediate = signImm;
                decoded.checkOverflow = (word.i.opcode == opAddi);
                case (word.i.opcode)
                    opSlti: decoded.aluCtrl = aluSlt;
                    opSltiu: decoded.aluCtrl = aluSltu;
                    opAndi: decoded.aluCtrl = aluAnd;
                    opOri: decoded.aluCtrl = aluOr;
                    opXori: decoded.aluCtrl = aluXor;
                    default: decoded.aluCtrl = aluAdd; // addi, addiu, lui
                endcase
                if (word.i.opcode == opAndi || word.i.opcode == opOri ||
                    word.i.opcode == opXori)
                    decoded.immediate = zeroImm;
                else if (word.i.opcode == opLui)
                    decoded.immediate = zeroImm << 16;
            end
            opLw, opLh, opLb, opLhu, opLbu:
            begin
                decoded.regRead1 = word.i.rs;
                decoded.memLoad = 1'b1;
                decoded.grfWriteSource = grfMem;
                decoded.destinationRegister = word.i.rt;
                decoded.immediate = signImm;
                decoded.calculateAddress = 1'b1;
                decoded.memReadSignExtend = (word.i.opcode == opLh) ||
                                            (word.i.opcode == opLb);
                case (word.i.opcode)
                    opLw: decoded.memWidthCtrl = memWidth4;
                    opLh, opLhu: decoded.memWidthCtrl = memWidth2;
                    default: decoded.memWidthCtrl = memWidth1;
                endcase
            end
            opSw, opSh, opSb:
            begin
                decoded.regRead1 = word.i.rs;
                decoded.regRead2 = word.i.rt; // store data
                decoded.memStore = 1'b1;
                decoded.immediate = signImm;
                decoded.calculateAddress = 1'b1;
                case (word.i.opcode)
                    opSw: decoded.memWidthCtrl = memWidth4;
                    opSh: decoded.memWidthCtrl = memWidth2;
                    default: decoded.memWidthCtrl = memWidth1;
                endcase
            end
            opBeq, opBne, opBlez, opBgtz, opBeql, opBnel, opBlezl, opBgtzl:
            begin
                decoded.regRead1 = word.i.rs;
                decoded.branch = 1'b1;
                decoded.immediate = signImm;
                decoded.branchLikely = word.i.opcode[4]; // likely forms at 0x14..0x17
                case (word.i.opcode)
                    opBeq, opBeql:
                    begin
                        decoded.regRead2 = word.i.rt;
                        decoded.cmpCtrl = cmpEqual;
                    end
                    opBne, opBnel:
                    begin
                        decoded.regRead2 = word.i.rt;
                        decoded.cmpCtrl = cmpNotEqual;
                    end
                    opBlez, opBlezl: decoded.cmpCtrl = cmpLessEqualZero;
                    default: decoded.cmpCtrl = cmpGreaterThanZero;
                endcase
            end
            opJ, opJal:
            begin
                decoded.absJump = 1'b1;
                decoded.absJumpLoc = jumpImmediate;
                decoded.immediate = {{(`WORD_WIDTH-26){1'b0}}, word.j.target26};
                if (word.j.opcode == opJal)
                begin
                    decoded.grfWriteSource = grfPc;
                    decoded.destinationRegister = `REG_INDEX_WIDTH'(`LINK_REGISTER);
                end
            end
            default:
            begin
                decoded.exception = excUnknownInstruction; // cop0, ll/sc, lwl..swr
            end
        endcase

        // likely branches are illegal when not supported
        if (!implementLikely && decoded.branchLikely)
            decoded.exception = excUnknownInstruction;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN || bubble)
            controls <= controlNop;
        else
            controls <= decoded;
    end

endmodule

`default_nettype wire

/* hdl/regimmDecoder.sv */
`include "mips_params.svh"

`default_nettype none

module regimmDecoder (
    subDecodeIf.decoder bus
);
    import isaPkg::*;
    import controlPkg::*;

    regimm_t code;

    assign code = regimm_t'(bus.instr.i.rt);

    always_comb
    begin
        bus.ctrl = controlNop;
        bus.unknown = 1'b0;
        bus.ctrl.regRead1 = bus.instr.i.rs;
        bus.ctrl.branch = 1'b1;
        bus.ctrl.immediate = bus.signImm;
        case (code)
            regimmBltz, regimmBltzl, regimmBltzal, regimmBltzall:
            begin
                bus.ctrl.cmpCtrl = cmpLessThanZero;
            end
            regimmBgez, regimmBgezl, regimmBgezal, regimmBgezall:
            begin
                bus.ctrl.cmpCtrl = cmpGreaterEqualZero;
            end
            default:
            begin
                bus.ctrl = controlNop; // traps land here too
                bus.unknown = 1'b1;
            end
        endcase

        case (code)
            regimmBltzl, regimmBgezl, regimmBltzall, regimmBgezall:
            begin
                bus.ctrl.branchLikely = 1'b1;
            end
            default:
            begin
                bus.ctrl.branchLikely = 1'b0;
            end
        endcase

        // link forms save the return address
        if (code == regimmBltzal || code == regimmBgezal ||
            code == regimmBltzall || code == regimmBgezall)
        begin
            bus.ctrl.grfWriteSource = grfPc;
            bus.ctrl.destinationRegister = `REG_INDEX_WIDTH'(`LINK_REGISTER);
        end
    end

endmodule

`default_nettype wire

/* hdl/specialDecoder.sv */
`default_nettype none

module specialDecoder (
    subDecodeIf.decoder bus
);
    import isaPkg::*;
    import controlPkg::*;

    // same ALU operation for the register, shamt and variable forms
    function automatic aluOp_t aluOpOf(input funct_t funct);
        case (funct)
            functAdd, functAddu: return aluAdd;
            functSub, functSubu: return aluSub;
            functAnd: return aluAnd;
            functOr: return aluOr;
            functNor: return aluNor;
            functXor: return aluXor;
            functSlt: return aluSlt;
            functSltu: return aluSltu;
            functSll, functSllv: return aluShiftLeft;
            functSrl, functSrlv: return aluShiftRight;
            functSra, functSrav: return aluArithmeticShiftRight;
            default: return aluAdd;
        endcase
    endfunction

    always_comb
    begin
        bus.ctrl = controlNop;
        bus.unknown = 1'b0;
        case (bus.instr.r.funct)
            functAdd, functAddu, functSub, functSubu, functAnd, functOr,
            functNor, functXor, functSlt, functSltu:
            begin
                bus.ctrl.regRead1 = bus.instr.r.rs;
                bus.ctrl.regRead2 = bus.instr.r.rt;
                bus.ctrl.grfWriteSource = grfAlu;
                bus.ctrl.destinationRegister = bus.instr.r.rd;
                bus.ctrl.aluCtrl = aluOpOf(bus.instr.r.funct);
                bus.ctrl.checkOverflow = (bus.instr.r.funct == functAdd) ||
                                         (bus.instr.r.funct == functSub);
            end
            functSll, functSrl, functSra:
            begin
                bus.ctrl.regRead1 = bus.instr.r.rt;
                bus.ctrl.grfWriteSource = grfAlu;
                bus.ctrl.destinationRegister = bus.instr.r.rd;
                bus.ctrl.aluCtrl = aluOpOf(bus.instr.r.funct);
                bus.ctrl.aluSrc = 1'b1;
                bus.ctrl.immediate[4:0] = bus.zeroImm[10:6]; // shamt, upper bits stay 0
            end
            functSllv, functSrlv, functSrav:
            begin
                bus.ctrl.regRead1 = bus.instr.r.rt;
                bus.ctrl.regRead2 = bus.instr.r.rs; // shift amount
                bus.ctrl.grfWriteSource = grfAlu;
                bus.ctrl.destinationRegister = bus.instr.r.rd;
                bus.ctrl.aluCtrl = aluOpOf(bus.instr.r.funct);
            end
            functJr, functJalr:
            begin
                bus.ctrl.regRead1 = bus.instr.r.rs;
                bus.ctrl.absJump = 1'b1;
                bus.ctrl.absJumpLoc = jumpRegister;
                if (bus.instr.r.funct == functJalr)
                begin
                    bus.ctrl.grfWriteSource = grfPc;
                    bus.ctrl.destinationRegister = bus.instr.r.rd;
                end
            end
            functSyscall:
            begin
                bus.ctrl.exception = excSyscall;
            end
            functBreak:
            begin
                bus.ctrl.exception = excBreak;
            end
            default:
            begin
                bus.unknown = 1'b1; // mult/div, traps and unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/subDecodeIf.sv */
`include "mips_params.svh"

`default_nettype none

interface subDecodeIf;
    import isaPkg::*;
    import controlPkg::*;

    instrWord_t instr;
    logic [`WORD_WIDTH-1:0] signImm;
    logic [`WORD_WIDTH-1:0] zeroImm;
    controlSignals_t ctrl;
    logic unknown;                 // no table entry for this word

    modport decoder (
        input instr,
        input signImm,
        input zeroImm,
        output ctrl,
        output unknown
    );

    modport merger (
        output instr,
        output signImm,
        output zeroImm,
        input ctrl,
        input unknown
    );

endinterface

`default_nettype wire

/* hdl/controlPkg.sv */
`include "mips_params.svh"

`default_nettype none

package controlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNor,
        aluXor,
        aluShiftLeft,
        aluShiftRight,
        aluArithmeticShiftRight,
        aluSlt,
        aluSltu
    } aluOp_t;

    typedef enum logic [2:0] {
        cmpEqual,
        cmpNotEqual,
        cmpLessThanZero,
        cmpLessEqualZero,
        cmpGreaterThanZero,
        cmpGreaterEqualZero
    } cmpOp_t;

    typedef enum logic [1:0] {
        grfNone,
        grfAlu,
        grfMem,
        grfPc
    } grfSource_t;

    // access size in bytes
    typedef enum logic [1:0] {
        memWidth1,
        memWidth2,
        memWidth4
    } memWidth_t;

    typedef enum logic {
        jumpImmediate,
        jumpRegister
    } jumpLoc_t;

    typedef enum logic [1:0] {
        excNone,
        excUnknownInstruction,
        excSyscall,
        excBreak
    } exception_t;

    typedef struct packed {
        logic [`REG_INDEX_WIDTH-1:0] regRead1;
        logic [`REG_INDEX_WIDTH-1:0] regRead2;
        logic [`REG_INDEX_WIDTH-1:0] destinationRegister;
        grfSource_t grfWriteSource;
        aluOp_t aluCtrl;
        logic aluSrc;              // 1 selects immediate as operand b
        logic [`WORD_WIDTH-1:0] immediate;
        logic checkOverflow;
        logic branch;
        logic branchLikely;
        cmpOp_t cmpCtrl;
        logic absJump;
        jumpLoc_t absJumpLoc;
        logic memLoad;
        logic memStore;
        memWidth_t memWidthCtrl;
        logic memReadSignExtend;
        logic calculateAddress;
        exception_t exception;
    } controlSignals_t;

    localparam controlSignals_t controlNop = '{
        regRead1: '0,
        regRead2: '0,
        destinationRegister: '0,
        grfWriteSource: grfNone,
        aluCtrl: aluAdd,
        aluSrc: 1'b0,
        immediate: '0,
        checkOverflow: 1'b0,
        branch: 1'b0,
        branchLikely: 1'b0,
        cmpCtrl: cmpEqual,
        absJump: 1'b0,
        absJumpLoc: jumpImmediate,
        memLoad: 1'b0,
        memStore: 1'b0,
        memWidthCtrl: memWidth1,
        memReadSignExtend: 1'b0,
        calculateAddress: 1'b0,
        exception: excNone
    };

endpackage

`default_nettype wire

/* hdl/isaPkg.sv */
`include "mips_params.svh"

`default_nettype none

package isaPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opBeql    = 6'b010100,
        opBnel    = 6'b010101,
        opBlezl   = 6'b010110,
        opBgtzl   = 6'b010111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        functSll     = 6'b000000,
        functSrl     = 6'b000010,
        functSra     = 6'b000011,
        functSllv    = 6'b000100,
        functSrlv    = 6'b000110,
        functSrav    = 6'b000111,
        functJr      = 6'b001000,
        functJalr    = 6'b001001,
        functSyscall = 6'b001100,
        functBreak   = 6'b001101,
        functAdd     = 6'b100000,
        functAddu    = 6'b100001,
        functSub     = 6'b100010,
        functSubu    = 6'b100011,
        functAnd     = 6'b100100,
        functOr      = 6'b100101,
        functXor     = 6'b100110,
        functNor     = 6'b100111,
        functSlt     = 6'b101010,
        functSltu    = 6'b101011
    } funct_t;

    // rt field of a REGIMM word
    typedef enum logic [4:0] {
        regimmBltz    = 5'b00000,
        regimmBgez    = 5'b00001,
        regimmBltzl   = 5'b00010,
        regimmBgezl   = 5'b00011,
        regimmBltzal  = 5'b10000,
        regimmBgezal  = 5'b10001,
        regimmBltzall = 5'b10010,
        regimmBgezall = 5'b10011
    } regimm_t;

    typedef struct packed {
        opcode_t opcode;
        logic [`REG_INDEX_WIDTH-1:0] rs;
        logic [`REG_INDEX_WIDTH-1:0] rt;
        logic [`REG_INDEX_WIDTH-1:0] rd;
        logic [4:0] shamt;
        funct_t funct;
    } rType_t;

    typedef struct packed {
        opcode_t opcode;
        logic [`REG_INDEX_WIDTH-1:0] rs;
        logic [`REG_INDEX_WIDTH-1:0] rt;
        logic [15:0] imm16;
    } iType_t;

    typedef struct packed {
        opcode_t opcode;
        logic [25:0] target26;
    } jType_t;

    typedef union packed {
        logic [`WORD_WIDTH-1:0] raw;
        rType_t r;
        iType_t i;
        jType_t j;
    } instrWord_t;

endpackage

`default_nettype wire

/* hdl/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// instruction word and immediate width
`define WORD_WIDTH 32

// register file index width
`define REG_INDEX_WIDTH 5

// return address register, $ra
`define LINK_REGISTER 31

// branch-likely forms decoded unless a build turns them off
`define IMPLEMENT_LIKELY_DEFAULT 1

`endif
